// ==== vlog.f ====
+incdir+hdl
+incdir+tests
hdl/riscv_pkg.sv
hdl/decode_if.sv
hdl/riscv_decoder_ctl_imm.sv
hdl/decode_credit_counter.sv
hdl/decode_ctl_fsm.sv
hdl/decode_issue_reg.sv
hdl/decode_stage.sv
tests/tb_decode_stage.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TB_TOP    := tb_decode_stage
RTL_TOP   := decode_stage
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides the result, a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_decode_vectors.svh ====
/*
 * decode stage test vectors
 * instruction words with the bundle each one must produce
 */
`ifndef TB_DECODE_VECTORS_SVH
`define TB_DECODE_VECTORS_SVH

localparam int NUM_VECS = 32;

// instr, compressed, imm, alu_op, lsu_op, br_op, then the flags
// rd_en use_imm use_pc alu lsu jal lui auipc illegal
localparam logic [84:0] VECS [NUM_VECS] = '{
  // full-length alu forms
  {32'h002081B3, 1'b0, 32'h00000000, 4'd0, 4'd0, 3'd0, 9'b100100000}, // add
  {32'h407302B3, 1'b0, 32'h00000000, 4'd1, 4'd0, 3'd0, 9'b100100000}, // sub
  {32'hFFB00093, 1'b0, 32'hFFFFFFFB, 4'd0, 4'd0, 3'd0, 9'b110100000}, // addi -5
  {32'h4071D113, 1'b0, 32'h00000007, 4'd7, 4'd0, 3'd0, 9'b110100000}, // srai 7
  {32'h0F027213, 1'b0, 32'h000000F0, 4'd2, 4'd0, 3'd0, 9'b110100000}, // andi
  {32'h00113093, 1'b0, 32'h00000001, 4'd9, 4'd0, 3'd0, 9'b110100000}, // sltiu
  // loads and stores, mul in between halts the stage
  {32'h00812283, 1'b0, 32'h00000008, 4'd0, 4'd1, 3'd0, 9'b110010000}, // lw
  {32'h023100B3, 1'b0, 32'h00000000, 4'd0, 4'd0, 3'd0, 9'b000000001}, // mul
  {32'hFFF0C303, 1'b0, 32'hFFFFFFFF, 4'd0, 4'd5, 3'd0, 9'b110010000}, // lbu -1
  {32'h00712623, 1'b0, 32'h0000000C, 4'd0, 4'd6, 3'd0, 9'b010010000}, // sw
  {32'hFE119E23, 1'b0, 32'hFFFFFFFC, 4'd0, 4'd7, 3'd0, 9'b010010000}, // sh -4
  // branches, jumps and upper immediates
  {32'h00208863, 1'b0, 32'h00000010, 4'd0, 4'd0, 3'd1, 9'b011000000}, // beq +16
  {32'hFE41FCE3, 1'b0, 32'hFFFFFFF8, 4'd0, 4'd0, 3'd6, 9'b011000000}, // bgeu -8
  {32'h001000EF, 1'b0, 32'h00000800, 4'd0, 4'd0, 3'd0, 9'b110101000}, // jal
  {32'h00408067, 1'b0, 32'h00000004, 4'd0, 4'd0, 3'd0, 9'b110101000}, // jalr
  {32'h123452B7, 1'b0, 32'h12345000, 4'd0, 4'd0, 3'd0, 9'b110100100}, // lui
  {32'hFFFFF317, 1'b0, 32'hFFFFF000, 4'd0, 4'd0, 3'd0, 9'b111100010}, // auipc
  // compressed forms
  {32'h000010F5, 1'b1, 32'hFFFFFFFD, 4'd0, 4'd0, 3'd0, 9'b110100000}, // c.addi
  {32'h00004115, 1'b1, 32'h00000005, 4'd0, 4'd0, 3'd0, 9'b110100000}, // c.li
  {32'h00006185, 1'b1, 32'h00001000, 4'd0, 4'd0, 3'd0, 9'b110100100}, // c.lui
  {32'h00008216, 1'b1, 32'h00000000, 4'd0, 4'd0, 3'd0, 9'b100100000}, // c.mv
  {32'h00009216, 1'b1, 32'h00000000, 4'd0, 4'd0, 3'd0, 9'b100100000}, // c.add
  {32'h00008C05, 1'b1, 32'h00000000, 4'd1, 4'd0, 3'd0, 9'b100100000}, // c.sub
  // csr write, second halt
  {32'h300110F3, 1'b0, 32'h00000000, 4'd0, 4'd0, 3'd0, 9'b000000001}, // csrrw
  {32'h0000A011, 1'b1, 32'h00000004, 4'd0, 4'd0, 3'd0, 9'b010101000}, // c.j
  {32'h00003FFD, 1'b1, 32'hFFFFFFFE, 4'd0, 4'd0, 3'd0, 9'b110101000}, // c.jal
  {32'h0000C401, 1'b1, 32'h00000008, 4'd0, 4'd0, 3'd1, 9'b011000000}, // c.beqz
  {32'h0000FCF5, 1'b1, 32'hFFFFFFFC, 4'd0, 4'd0, 3'd2, 9'b011000000}, // c.bnez
  {32'h000040C0, 1'b1, 32'h00000004, 4'd0, 4'd1, 3'd0, 9'b110010000}, // c.lw
  {32'h0000C028, 1'b1, 32'h00000040, 4'd0, 4'd6, 3'd0, 9'b010010000}, // c.sw
  {32'h000040B2, 1'b1, 32'h0000000C, 4'd0, 4'd1, 3'd0, 9'b110010000}, // c.lwsp
  {32'h0000C40A, 1'b1, 32'h00000008, 4'd0, 4'd6, 3'd0, 9'b010010000}  // c.swsp
};

`endif

// ==== tests/tb_decode_stage.sv ====
/*
 * decode stage testbench
 * table-driven decode checks with random credit return and halt recovery
 */
`timescale 1ns/1ns
`include "riscv_macros.svh"

module tb_decode_stage;

  typedef struct packed {
    logic [31:0] instr;
    logic        compressed;
    logic [31:0] imm;
    logic [3:0]  alu_op;
    logic [3:0]  lsu_op;
    logic [2:0]  br_op;
    logic [8:0]  flags;
  } vec_t;

  `include "tb_decode_vectors.svh"

  localparam int ROW_BOUND = 20;

  logic                   clk;
  logic                   rst_n;
  logic [31:0]            instr;
  logic                   compressed;
  logic                   instr_valid;
  logic                   instr_ready;
  logic                   credit_return = 1'b0;
  logic                   halt_clear;
  logic                   out_valid;
  logic [`DATA_WIDTH-1:0] out_imm;
  riscv_pkg::alu_op_e     out_alu_op;
  riscv_pkg::lsu_op_e     out_lsu_op;
  riscv_pkg::br_op_e      out_br_op;
  logic                   out_rd_en;
  logic                   out_use_imm;
  logic                   out_use_pc;
  logic                   out_alu;
  logic                   out_lsu;
  logic                   out_jal;
  logic                   out_lui;
  logic                   out_auipc;
  logic                   out_illegal;

  int          exp_q[$];
  int          issued;
  int          returned;
  int          rows_seen;
  int          errors;
  int          credit_fails;
  int          tests_run;
  int          tests_failed;
  logic [15:0] lfsr = 16'd49;

  decode_stage i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .compressed   (compressed),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .credit_return(credit_return),
    .halt_clear   (halt_clear),
    .out_valid    (out_valid),
    .out_imm      (out_imm),
    .out_alu_op   (out_alu_op),
    .out_lsu_op   (out_lsu_op),
    .out_br_op    (out_br_op),
    .out_rd_en    (out_rd_en),
    .out_use_imm  (out_use_imm),
    .out_use_pc   (out_use_pc),
    .out_alu      (out_alu),
    .out_lsu      (out_lsu),
    .out_jal      (out_jal),
    .out_lui      (out_lui),
    .out_auipc    (out_auipc),
    .out_illegal  (out_illegal)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int fails);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
      fails++;
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int fails);
    tests_run++;
    if (fails != 0) begin
      tests_failed++;
    end
    $display("%s: %s", name, (fails == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // execute side, returns a credit on a random cycle while one is owed
  always @(posedge clk) begin
    if (!rst_n) begin
      credit_return <= 1'b0;
    end else if (issued > returned) begin
      lfsr = lfsr_next(lfsr);
      credit_return <= lfsr[0];
      if (lfsr[0]) begin
        returned++;
      end
    end else begin
      credit_return <= 1'b0;
    end
  end

  // scoreboard and credit bookkeeping, sampled mid-cycle
  always @(negedge clk) begin : scoreboard
    int   idx;
    int   fails;
    vec_t v;
    if (rst_n && out_valid) begin
      issued++;
      if (exp_q.size() == 0) begin
        $display("out_valid was raised with no accepted instruction pending");
        errors++;
        credit_fails++;
      end else begin
        idx   = exp_q.pop_front();
        v     = vec_t'(VECS[idx]);
        fails = 0;
        compare_value("out_imm", out_imm, v.imm, fails);
        compare_value("out_alu_op", 32'(out_alu_op), 32'(v.alu_op), fails);
        compare_value("out_lsu_op", 32'(out_lsu_op), 32'(v.lsu_op), fails);
        compare_value("out_br_op", 32'(out_br_op), 32'(v.br_op), fails);
        compare_value("out_rd_en", 32'(out_rd_en), 32'(v.flags[8]), fails);
        compare_value("out_use_imm", 32'(out_use_imm), 32'(v.flags[7]), fails);
        compare_value("out_use_pc", 32'(out_use_pc), 32'(v.flags[6]), fails);
        compare_value("out_alu", 32'(out_alu), 32'(v.flags[5]), fails);
        compare_value("out_lsu", 32'(out_lsu), 32'(v.flags[4]), fails);
        compare_value("out_jal", 32'(out_jal), 32'(v.flags[3]), fails);
        compare_value("out_lui", 32'(out_lui), 32'(v.flags[2]), fails);
        compare_value("out_auipc", 32'(out_auipc), 32'(v.flags[1]), fails);
        compare_value("out_illegal", 32'(out_illegal), 32'(v.flags[0]), fails);
        rows_seen++;
        report_test($sformatf("row %0d instr 0x%08h", idx, v.instr), fails);
      end
    end
    if (rst_n) begin
      if (issued - returned > `DEC_CREDITS) begin
        $display("more bundles outstanding than execute has buffer slots");
        errors++;
        credit_fails++;
      end
      if (issued - returned == `DEC_CREDITS) begin
        compare_value("instr_ready", 32'(instr_ready), 32'd0, credit_fails);
      end
    end
  end

  initial begin : main_seq
    int   reset_fails;
    int   halt_fails;
    vec_t v;
    reset_fails = 0;
    rst_n       = 1'b0;
    instr       = '0;
    compressed  = 1'b0;
    instr_valid = 1'b0;
    halt_clear  = 1'b0;
    repeat (3) begin
      @(negedge clk);
      compare_value("out_valid", 32'(out_valid), 32'd0, reset_fails);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_value("instr_ready", 32'(instr_ready), 32'd1, reset_fails);
    compare_value("out_valid", 32'(out_valid), 32'd0, reset_fails);
    report_test("reset", reset_fails);

    @(posedge clk);
    for (int i = 0; i < NUM_VECS; i++) begin
      v = vec_t'(VECS[i]);
      instr       <= v.instr;
      compressed  <= v.compressed;
      instr_valid <= 1'b1;
      // ready seen mid-cycle means the transfer happens on the next edge
      @(negedge clk);
      while (!instr_ready) begin
        @(negedge clk);
      end
      exp_q.push_back(i);
      @(posedge clk);
      if (v.flags[0]) begin
        halt_fails = 0;
        instr_valid <= 1'b0;
        repeat (3) begin
          @(negedge clk);
          compare_value("instr_ready", 32'(instr_ready), 32'd0, halt_fails);
        end
        @(posedge clk);
        halt_clear <= 1'b1;
        @(negedge clk);
        compare_value("instr_ready", 32'(instr_ready), 32'd0, halt_fails);
        @(posedge clk);
        halt_clear <= 1'b0;
        report_test($sformatf("halt after row %0d", i), halt_fails);
      end
    end
    instr_valid <= 1'b0;

    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    if (rows_seen != NUM_VECS) begin
      $display("only %0d of %0d rows came out of the stage", rows_seen, NUM_VECS);
      errors++;
      credit_fails++;
    end
    report_test("credit flow", credit_fails);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // bound of ROW_BOUND cycles per row plus reset
  initial begin : watchdog
    repeat (NUM_VECS * ROW_BOUND + 16) begin
      @(posedge clk);
    end
    $display("timeout: the stage stopped after %0d of %0d rows", rows_seen, NUM_VECS);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== hdl/decode_stage.sv ====
/*
 * rv32 decode stage top
 * decoder, credit flow control and issue register
 */
`timescale 1ns/1ns
`include "riscv_macros.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [31:0]            instr,
  input  logic                   compressed,
  input  logic                   instr_valid,
  output logic                   instr_ready,
  input  logic                   credit_return,
  input  logic                   halt_clear,
  output logic                   out_valid,
  output logic [`DATA_WIDTH-1:0] out_imm,
  output riscv_pkg::alu_op_e     out_alu_op,
  output riscv_pkg::lsu_op_e     out_lsu_op,
  output riscv_pkg::br_op_e      out_br_op,
  output logic                   out_rd_en,
  output logic                   out_use_imm,
  output logic                   out_use_pc,
  output logic                   out_alu,
  output logic                   out_lsu,
  output logic                   out_jal,
  output logic                   out_lui,
  output logic                   out_auipc,
  output logic                   out_illegal
);

  logic load;
  logic credit_avail;

  decode_if dec_bus ();

  riscv_decoder_ctl_imm i_decoder (
    .instr     (instr),
    .compressed(compressed),
    .dec       (dec_bus.source)
  );

  // every load is an issue, so it debits one credit
  decode_credit_counter i_credit (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (load),
    .credit_return(credit_return),
    .credit_avail (credit_avail)
  );

  decode_ctl_fsm i_ctl (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .illegal     (dec_bus.illegal),
    .credit_avail(credit_avail),
    .halt_clear  (halt_clear),
    .instr_ready (instr_ready),
    .load        (load)
  );

  decode_issue_reg i_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .dec        (dec_bus.sink),
    .out_valid  (out_valid),
    .out_imm    (out_imm),
    .out_alu_op (out_alu_op),
    .out_lsu_op (out_lsu_op),
    .out_br_op  (out_br_op),
    .out_rd_en  (out_rd_en),
    .out_use_imm(out_use_imm),
    .out_use_pc (out_use_pc),
    .out_alu    (out_alu),
    .out_lsu    (out_lsu),
    .out_jal    (out_jal),
    .out_lui    (out_lui),
    .out_auipc  (out_auipc),
    .out_illegal(out_illegal)
  );

endmodule

// ==== hdl/decode_issue_reg.sv ====
/*
 * issue register
 * captures the decoded bundle and presents it to execute for one cycle
 */
`timescale 1ns/1ns
`include "riscv_macros.svh"

module decode_issue_reg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load,
  decode_if.sink                 dec,
  output logic                   out_valid,
  output logic [`DATA_WIDTH-1:0] out_imm,
  output riscv_pkg::alu_op_e     out_alu_op,
  output riscv_pkg::lsu_op_e     out_lsu_op,
  output riscv_pkg::br_op_e      out_br_op,
  output logic                   out_rd_en,
  output logic                   out_use_imm,
  output logic                   out_use_pc,
  output logic                   out_alu,
  output logic                   out_lsu,
  output logic                   out_jal,
  output logic                   out_lui,
  output logic                   out_auipc,
  output logic                   out_illegal
);

  // one pulse per accepted instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= load;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_imm     <= dec.imm;
      out_alu_op  <= dec.alu_op;
      out_lsu_op  <= dec.lsu_op;
      out_br_op   <= dec.br_op;
      out_rd_en   <= dec.rd_en;
      out_use_imm <= dec.use_imm;
      out_use_pc  <= dec.use_pc;
      out_alu     <= dec.alu;
      out_lsu     <= dec.lsu;
      out_jal     <= dec.jal;
      out_lui     <= dec.lui;
      out_auipc   <= dec.auipc;
      out_illegal <= dec.illegal;
    end
  end

endmodule

// ==== hdl/decode_ctl_fsm.sv ====
/*
 * decode stage control
 * run, credit stall and halt on an illegal instruction
 */
`timescale 1ns/1ns

module decode_ctl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic instr_valid,
  input  logic illegal,
  input  logic credit_avail,
  input  logic halt_clear,
  output logic instr_ready,
  output logic load
);

  riscv_pkg::dec_state_e state;
  riscv_pkg::dec_state_e state_next;

  // ready follows the credit count directly
  // stall marks the cycles after the counter reported empty
  assign instr_ready = (state != riscv_pkg::HALT) && credit_avail;
  assign load        = instr_valid && instr_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= riscv_pkg::RUN;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      riscv_pkg::RUN, riscv_pkg::STALL: begin
        if (load && illegal) begin
          state_next = riscv_pkg::HALT;
        end else if (credit_avail) begin
          state_next = riscv_pkg::RUN;
        end else begin
          state_next = riscv_pkg::STALL;
        end
      end
      riscv_pkg::HALT: begin
        if (halt_clear) begin
          state_next = credit_avail ? riscv_pkg::RUN : riscv_pkg::STALL;
        end
      end
      default: state_next = riscv_pkg::RUN;
    endcase
  end

  a_no_load_halt: assert property (@(posedge clk) disable iff (!rst_n)
    state == riscv_pkg::HALT |-> !load);

endmodule

// ==== hdl/decode_credit_counter.sv ====
/*
 * issue credit counter
 * tracks free slots in the execute input buffer
 */
`timescale 1ns/1ns
`include "riscv_macros.svh"

module decode_credit_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic issue,
  input  logic credit_return,
  output logic credit_avail
);

  logic [`CREDIT_CNT_W-1:0] credit_cnt;

  // issue and return in one cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= `CREDIT_CNT_W'(`DEC_CREDITS);
    end else if (issue && !credit_return) begin
      credit_cnt <= credit_cnt - 1'b1;
    end else if (credit_return && !issue) begin
      credit_cnt <= credit_cnt + 1'b1;
    end
  end

  // registered count, a returned credit is usable the next cycle
  assign credit_avail = (credit_cnt != '0);

  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= `CREDIT_CNT_W'(`DEC_CREDITS));

  a_no_issue_empty: assert property (@(posedge clk) disable iff (!rst_n)
    issue |-> credit_cnt != '0);

endmodule

// ==== hdl/riscv_decoder_ctl_imm.sv ====
/*
 * rv32ic instruction decoder
 * builds the immediate, the unit opcodes and the operand flags
 */
`timescale 1ns/1ns
`include "riscv_macros.svh"

module riscv_decoder_ctl_imm (
  input  logic [31:0] instr,
  input  logic        compressed,
  decode_if.source    dec
);

  logic [15:0] in16;

  logic [`DATA_WIDTH-1:0] imm_i;
  logic [`DATA_WIDTH-1:0] imm_s;
  logic [`DATA_WIDTH-1:0] imm_b;
  logic [`DATA_WIDTH-1:0] imm_u;
  logic [`DATA_WIDTH-1:0] imm_j;
  logic [`DATA_WIDTH-1:0] imm_shamt;

  logic [`DATA_WIDTH-1:0] c_imm6;
  logic [`DATA_WIDTH-1:0] c_imm_j;
  logic [`DATA_WIDTH-1:0] c_imm_b;
  logic [`DATA_WIDTH-1:0] c_imm_lui;
  logic [`DATA_WIDTH-1:0] c_imm_lwsw;
  logic [`DATA_WIDTH-1:0] c_imm_lwsp;
  logic [`DATA_WIDTH-1:0] c_imm_swsp;

  assign in16      = instr[15:0];

  assign imm_i     = {{20{instr[31]}}, instr[31:20]};
  assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u     = {instr[31:12], 12'b0};
  assign imm_j     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  // shift amount only, funct7 stays out of the operand
  assign imm_shamt = {27'b0, instr[24:20]};

  assign c_imm6     = {{27{in16[12]}}, in16[6:2]};
  assign c_imm_j    = {{21{in16[12]}}, in16[8], in16[10:9], in16[6], in16[7], in16[2],
                       in16[11], in16[5:3], 1'b0};
  assign c_imm_b    = {{24{in16[12]}}, in16[6:5], in16[2], in16[11:10], in16[4:3], 1'b0};
  assign c_imm_lui  = {{15{in16[12]}}, in16[6:2], 12'b0};
  assign c_imm_lwsw = {25'b0, in16[5], in16[12:10], in16[6], 2'b00};
  assign c_imm_lwsp = {24'b0, in16[3:2], in16[12], in16[6:4], 2'b00};
  assign c_imm_swsp = {24'b0, in16[8:7], in16[12:9], 2'b00};

  always_comb begin
    dec.imm     = '0;
    dec.alu_op  = riscv_pkg::ALU_ADD;
    dec.lsu_op  = riscv_pkg::LSU_NONE;
    dec.br_op   = riscv_pkg::BR_NONE;
    dec.rd_en   = 1'b0;
    dec.use_imm = 1'b0;
    dec.use_pc  = 1'b0;
    dec.alu     = 1'b0;
    dec.lsu     = 1'b0;
    dec.jal     = 1'b0;
    dec.lui     = 1'b0;
    dec.auipc   = 1'b0;
    dec.illegal = 1'b0;

    if (compressed) begin
      casez (in16)
        `C_ADDI, `C_LI: begin
          {dec.alu, dec.rd_en, dec.use_imm} = 3'b111;
          dec.imm = c_imm6;
        end
        `C_LUI: begin
          // rd of x2 is c.addi16sp, not decoded here
          if (in16[11:7] == 5'd2) begin
            dec.illegal = 1'b1;
          end else begin
            {dec.alu, dec.rd_en, dec.use_imm, dec.lui} = 4'b1111;
            dec.imm = c_imm_lui;
          end
        end
        `C_SUB: begin
          {dec.alu, dec.rd_en} = 2'b11;
          dec.alu_op = riscv_pkg::ALU_SUB;
        end
        `C_MV, `C_ADD: begin
          // rs2 of x0 selects c.jr, c.jalr or c.ebreak
          if (in16[6:2] == 5'd0) begin
            dec.illegal = 1'b1;
          end else begin
            {dec.alu, dec.rd_en} = 2'b11;
          end
        end
        `C_J, `C_JAL: begin
          {dec.jal, dec.alu, dec.use_imm} = 3'b111;
          // only c.jal links into x1
          dec.rd_en = !in16[15];
          dec.imm   = c_imm_j;
        end
        `C_BEQZ, `C_BNEZ: begin
          {dec.use_pc, dec.use_imm} = 2'b11;
          dec.br_op = in16[13] ? riscv_pkg::BR_BNE : riscv_pkg::BR_BEQ;
          dec.imm   = c_imm_b;
        end
        `C_LW, `C_LWSP: begin
          {dec.lsu, dec.rd_en, dec.use_imm} = 3'b111;
          dec.lsu_op = riscv_pkg::LSU_LW;
          dec.imm    = in16[1] ? c_imm_lwsp : c_imm_lwsw;
        end
        `C_SW, `C_SWSP: begin
          {dec.lsu, dec.use_imm} = 2'b11;
          dec.lsu_op = riscv_pkg::LSU_SW;
          dec.imm    = in16[1] ? c_imm_swsp : c_imm_lwsw;
        end
        default: dec.illegal = 1'b1;
      endcase
    end else begin
      // legality and opcode first, operand format follows from the major opcode
      casez (instr)
        `ADD, `ADDI:   dec.alu_op = riscv_pkg::ALU_ADD;
        `SUB:          dec.alu_op = riscv_pkg::ALU_SUB;
        `AND, `ANDI:   dec.alu_op = riscv_pkg::ALU_AND;
        `OR, `ORI:     dec.alu_op = riscv_pkg::ALU_OR;
        `XOR, `XORI:   dec.alu_op = riscv_pkg::ALU_XOR;
        `SLL, `SLLI:   dec.alu_op = riscv_pkg::ALU_SLL;
        `SRL, `SRLI:   dec.alu_op = riscv_pkg::ALU_SRL;
        `SRA, `SRAI:   dec.alu_op = riscv_pkg::ALU_SRA;
        `SLT, `SLTI:   dec.alu_op = riscv_pkg::ALU_SLT;
        `SLTU, `SLTIU: dec.alu_op = riscv_pkg::ALU_SLTU;
        `LW:           dec.lsu_op = riscv_pkg::LSU_LW;
        `LH:           dec.lsu_op = riscv_pkg::LSU_LH;
        `LB:           dec.lsu_op = riscv_pkg::LSU_LB;
        `LHU:          dec.lsu_op = riscv_pkg::LSU_LHU;
        `LBU:          dec.lsu_op = riscv_pkg::LSU_LBU;
        `SW:           dec.lsu_op = riscv_pkg::LSU_SW;
        `SH:           dec.lsu_op = riscv_pkg::LSU_SH;
        `SB:           dec.lsu_op = riscv_pkg::LSU_SB;
        `BEQ:          dec.br_op  = riscv_pkg::BR_BEQ;
        `BNE:          dec.br_op  = riscv_pkg::BR_BNE;
        `BLT:          dec.br_op  = riscv_pkg::BR_BLT;
        `BGE:          dec.br_op  = riscv_pkg::BR_BGE;
        `BLTU:         dec.br_op  = riscv_pkg::BR_BLTU;
        `BGEU:         dec.br_op  = riscv_pkg::BR_BGEU;
        `JAL, `JALR, `LUI, `AUIPC: ;
        default:       dec.illegal = 1'b1;
      endcase

      if (!dec.illegal) begin
        case (instr[6:0])
          // register-register alu
          7'b0110011: {dec.alu, dec.rd_en} = 2'b11;
          7'b0010011: begin
            {dec.alu, dec.rd_en, dec.use_imm} = 3'b111;
            // funct3 001 and 101 are the shifts
            dec.imm = (instr[13:12] == 2'b01) ? imm_shamt : imm_i;
          end
          7'b0000011: begin
            {dec.lsu, dec.rd_en, dec.use_imm} = 3'b111;
            dec.imm = imm_i;
          end
          7'b0100011: begin
            {dec.lsu, dec.use_imm} = 2'b11;
            dec.imm = imm_s;
          end
          7'b1100011: begin
            {dec.use_pc, dec.use_imm} = 2'b11;
            dec.imm = imm_b;
          end
          7'b1101111, 7'b1100111: begin
            {dec.jal, dec.alu, dec.rd_en, dec.use_imm} = 4'b1111;
            dec.imm = instr[3] ? imm_j : imm_i;
          end
          7'b0110111: begin
            {dec.lui, dec.alu, dec.rd_en, dec.use_imm} = 4'b1111;
            dec.imm = imm_u;
          end
          7'b0010111: begin
            {dec.auipc, dec.alu, dec.rd_en, dec.use_imm, dec.use_pc} = 5'b11111;
            dec.imm = imm_u;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== hdl/decode_if.sv ====
/*
 * decoded control bundle, decoder to issue register
 */
`timescale 1ns/1ns
`include "riscv_macros.svh"

interface decode_if;

  logic [`DATA_WIDTH-1:0] imm;
  riscv_pkg::alu_op_e     alu_op;
  riscv_pkg::lsu_op_e     lsu_op;
  riscv_pkg::br_op_e      br_op;
  logic                   rd_en;
  logic                   use_imm;
  logic                   use_pc;
  logic                   alu;
  logic                   lsu;
  logic                   jal;
  logic                   lui;
  logic                   auipc;
  logic                   illegal;

  modport source (
    output imm, alu_op, lsu_op, br_op, rd_en, use_imm, use_pc,
    output alu, lsu, jal, lui, auipc, illegal
  );

  modport sink (
    input imm, alu_op, lsu_op, br_op, rd_en, use_imm, use_pc,
    input alu, lsu, jal, lui, auipc, illegal
  );

endinterface

// ==== hdl/riscv_pkg.sv ====
/*
 * rv32 decode types
 * opcode encodings for execute and the stage states
 */
package riscv_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // nine load/store codes, so four bits wide
  typedef enum logic [3:0] {
    LSU_NONE,
    LSU_LW,
    LSU_LH,
    LSU_LB,
    LSU_LHU,
    LSU_LBU,
    LSU_SW,
    LSU_SH,
    LSU_SB
  } lsu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU
  } br_op_e;

  typedef enum logic [1:0] {
    RUN,
    STALL,
    HALT
  } dec_state_e;

endpackage

// ==== hdl/riscv_macros.svh ====
/*
 * rv32 decode stage definitions
 * widths, issue credit depth and instruction match patterns
 */
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

`define DATA_WIDTH 32

// buffer slots held by execute, also the credit count after reset
`define DEC_CREDITS 2
`define CREDIT_CNT_W ($clog2((`DEC_CREDITS) + 1))

// full-length forms, fields are funct7 rs2 rs1 funct3 rd opcode
`define LUI   32'b????????????????????_?????_0110111
`define AUIPC 32'b????????????????????_?????_0010111
`define JAL   32'b????????????????????_?????_1101111
`define JALR  32'b????????????_?????_000_?????_1100111

`define BEQ   32'b???????_?????_?????_000_?????_1100011
`define BNE   32'b???????_?????_?????_001_?????_1100011
`define BLT   32'b???????_?????_?????_100_?????_1100011
`define BGE   32'b???????_?????_?????_101_?????_1100011
`define BLTU  32'b???????_?????_?????_110_?????_1100011
`define BGEU  32'b???????_?????_?????_111_?????_1100011

`define LB    32'b????????????_?????_000_?????_0000011
`define LH    32'b????????????_?????_001_?????_0000011
`define LW    32'b????????????_?????_010_?????_0000011
`define LBU   32'b????????????_?????_100_?????_0000011
`define LHU   32'b????????????_?????_101_?????_0000011
`define SB    32'b???????_?????_?????_000_?????_0100011
`define SH    32'b???????_?????_?????_001_?????_0100011
`define SW    32'b???????_?????_?????_010_?????_0100011

`define ADDI  32'b????????????_?????_000_?????_0010011
`define SLTI  32'b????????????_?????_010_?????_0010011
`define SLTIU 32'b????????????_?????_011_?????_0010011
`define XORI  32'b????????????_?????_100_?????_0010011
`define ORI   32'b????????????_?????_110_?????_0010011
`define ANDI  32'b????????????_?????_111_?????_0010011
`define SLLI  32'b0000000_?????_?????_001_?????_0010011
`define SRLI  32'b0000000_?????_?????_101_?????_0010011
`define SRAI  32'b0100000_?????_?????_101_?????_0010011

`define ADD   32'b0000000_?????_?????_000_?????_0110011
`define SUB   32'b0100000_?????_?????_000_?????_0110011
`define SLL   32'b0000000_?????_?????_001_?????_0110011
`define SLT   32'b0000000_?????_?????_010_?????_0110011
`define SLTU  32'b0000000_?????_?????_011_?????_0110011
`define XOR   32'b0000000_?????_?????_100_?????_0110011
`define SRL   32'b0000000_?????_?????_101_?????_0110011
`define SRA   32'b0100000_?????_?????_101_?????_0110011
`define OR    32'b0000000_?????_?????_110_?????_0110011
`define AND   32'b0000000_?????_?????_111_?????_0110011

// compressed forms, matched on the low half-word
`define C_ADDI 16'b000_?_?????_?????_01
`define C_JAL  16'b001_???????????_01
`define C_LI   16'b010_?_?????_?????_01
`define C_LUI  16'b011_?_?????_?????_01
`define C_SUB  16'b100_0_11_???_00_???_01
`define C_J    16'b101_???????????_01
`define C_BEQZ 16'b110_???_???_?????_01
`define C_BNEZ 16'b111_???_???_?????_01
`define C_LW   16'b010_???_???_??_???_00
`define C_SW   16'b110_???_???_??_???_00
`define C_LWSP 16'b010_?_?????_?????_10
`define C_SWSP 16'b110_??????_?????_10
`define C_MV   16'b100_0_?????_?????_10
`define C_ADD  16'b100_1_?????_?????_10

`endif
